//--- rtl/block_fetch.sv
// coefficient fetch stage
`timescale 1ns/1ps
`include "idct_defs.svh"

module block_fetch (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 start_i,
	input  logic                 wb_done_i,
	input  idct_pkg::sram_req_t  wb_req_i,
	input  idct_pkg::sram_word_u sram_rdata_i,
	output idct_pkg::sram_req_t  sram_req_o,
	output idct_pkg::dp_port_t   buf_o,
	output logic                 fetch_busy_o,
	output logic                 fetch_done_o,
	output logic                 done_o
);
	import idct_pkg::*;

	localparam logic [17:0] ROW_W = 18'(8 * `IMG_W_BLOCKS);
	localparam logic [7:0] LAST_BCOL = 8'(`IMG_W_BLOCKS - 1);
	localparam logic [7:0] LAST_BROW = 8'(`IMG_H_BLOCKS - 1);

	typedef enum logic [1:0] {S_IDLE, S_FETCH, S_WAIT} state_t;

	state_t state;
	logic [7:0] brow;
	logic [7:0] bcol;
	logic [6:0] cnt; // reads issued
	logic [1:0] vld; // sram latency pipe
	logic [5:0] idx0;
	logic [5:0] idx1;
	logic [17:0] rd_addr;
	logic [17:0] row;
	logic [17:0] col;
	logic buf_we;
	logic [5:0] buf_addr;
	logic signed [31:0] buf_wdata;
	sram_req_t own_req;

	assign row = 18'({brow, cnt[5:3]});
	assign col = 18'({bcol, cnt[2:0]});

	always_ff @(posedge Clock or negedge Resetn) begin
		if (~Resetn) begin
			state <= S_IDLE;
			brow <= '0;
			bcol <= '0;
			cnt <= '0;
			vld <= '0;
			rd_addr <= `COEF_BASE;
			buf_we <= 1'b0;
			fetch_done_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			fetch_done_o <= 1'b0;
			done_o <= 1'b0;
			vld <= {vld[0], 1'b0};
			buf_we <= vld[1];
			case (state)
				S_IDLE: if (start_i) begin
					brow <= '0;
					bcol <= '0;
					cnt <= '0;
					state <= S_FETCH;
				end
				S_FETCH: begin
					if (!cnt[6]) begin
						rd_addr <= `COEF_BASE + row * ROW_W + col;
						cnt <= cnt + 7'd1;
						vld[0] <= 1'b1;
					end else if (vld == 2'b00 && !buf_we) begin
						fetch_done_o <= 1'b1; // last buffer write has landed
						state <= S_WAIT;
					end
				end
				S_WAIT: if (wb_done_i) begin
					cnt <= '0;
					if (bcol == LAST_BCOL) begin
						bcol <= '0;
						if (brow == LAST_BROW) begin
							brow <= '0;
							done_o <= 1'b1;
							state <= S_IDLE;
						end else begin
							brow <= brow + 8'd1;
							state <= S_FETCH;
						end
					end else begin
						bcol <= bcol + 8'd1;
						state <= S_FETCH;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (state == S_FETCH && !cnt[6]) begin
			idx0 <= cnt[5:0];
		end
		idx1 <= idx0;
		buf_addr <= idx1;
		buf_wdata <= {{16{sram_rdata_i.coef[15]}}, sram_rdata_i.coef};
	end

	always_comb begin
		own_req = '0;
		own_req.addr = rd_addr;
		own_req.we_n = 1'b1;
	end

	// result stage owns the bus while we wait
	assign sram_req_o = (state == S_WAIT) ? wb_req_i : own_req;
	assign buf_o = '{addr: {1'b0, buf_addr}, wdata: buf_wdata, we: buf_we};
	assign fetch_busy_o = (state == S_FETCH);

endmodule

//--- rtl/idct_coef_rom.sv
// IDCT constant table
`timescale 1ns/1ps

module idct_coef_rom (
	input  logic [5:0]      idx0_i,
	input  logic [5:0]      idx1_i,
	output idct_pkg::coef_t c0_o,
	output idct_pkg::coef_t c1_o
);
	import idct_pkg::*;

	// 2048*cos(m*pi/16), m over a full period
	function automatic coef_t cos_q(input logic [4:0] m);
		logic [4:0] f;
		logic neg;
		coef_t mag;
		f = (m > 5'd16) ? 5'(6'd32 - m) : m;
		neg = (f > 5'd8);
		if (neg) begin
			f = 5'd16 - f;
		end
		case (f[3:0])
			4'd0: mag = 16'sd2048;
			4'd1: mag = 16'sd2009;
			4'd2: mag = 16'sd1892;
			4'd3: mag = 16'sd1703;
			4'd4: mag = 16'sd1448;
			4'd5: mag = 16'sd1138;
			4'd6: mag = 16'sd784;
			4'd7: mag = 16'sd400;
			default: mag = 16'sd0;
		endcase
		return neg ? -mag : mag;
	endfunction

	// idx is {row, col}
	function automatic coef_t entry(input logic [5:0] idx);
		logic [6:0] prod;
		prod = {idx[5:3], 1'b1} * idx[2:0]; // (2r+1)k
		return (idx[2:0] == 3'd0) ? 16'sd1448 : cos_q(prod[4:0]);
	endfunction

	assign c0_o = entry(idx0_i);
	assign c1_o = entry(idx1_i);

endmodule

//--- rtl/idct_defs.svh
// IDCT geometry and SRAM map
`ifndef IDCT_DEFS_SVH
`define IDCT_DEFS_SVH

// plane size in 8x8 blocks
`define IMG_W_BLOCKS 2
`define IMG_H_BLOCKS 2

// word addresses of the two SRAM regions
`define COEF_BASE 18'd0
`define PIX_BASE 18'd16384

// arithmetic right shifts after each pass
`define T_SHIFT 8
`define S_SHIFT 16

`endif

//--- rtl/idct_dpram.sv
// dual-port block RAM
`timescale 1ns/1ps

module idct_dpram #(
	parameter int DEPTH = 128
) (
	input  logic               Clock,
	input  idct_pkg::dp_port_t a_i,
	input  idct_pkg::dp_port_t b_i,
	output logic signed [31:0] qa_o,
	output logic signed [31:0] qb_o
);
	localparam int AW = $clog2(DEPTH);

	logic signed [31:0] mem [DEPTH];

	// read returns old data on a same-cycle write
	always_ff @(posedge Clock) begin
		if (a_i.we) begin
			mem[a_i.addr[AW-1:0]] <= a_i.wdata;
		end
		if (b_i.we) begin
			mem[b_i.addr[AW-1:0]] <= b_i.wdata;
		end
		qa_o <= mem[a_i.addr[AW-1:0]];
		qb_o <= mem[b_i.addr[AW-1:0]];
	end

endmodule

//--- rtl/idct_matmul.sv
// IDCT two-pass multiply stage
`timescale 1ns/1ps
`include "idct_defs.svh"

module idct_matmul (
	input  logic               Clock,
	input  logic               Resetn,
	input  logic               fetch_done_i,
	input  logic signed [31:0] buf_q_i,
	output idct_pkg::dp_port_t buf_o,
	output idct_pkg::dp_port_t pix_o,
	output logic               calc_done_o
);
	import idct_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_LOAD, S_CALC} state_t;

	state_t state;
	logic pass; // 0 computes T, 1 computes S
	logic [2:0] outer; // S' row, then T column
	logic [2:0] inner; // output index within the line
	logic [1:0] kk; // k pair
	logic [3:0] ld_cnt;
	logic [1:0] vld;
	logic [2:0] idx0;
	logic [2:0] idx1;
	logic signed [31:0] vec [8]; // current line of operands
	logic signed [31:0] acc;
	logic signed [31:0] prod0;
	logic signed [31:0] prod1;
	logic signed [31:0] sum_nxt;
	logic signed [31:0] t_val;
	logic signed [31:0] s_val;
	logic [7:0] pix_val;
	coef_t c0;
	coef_t c1;
	logic buf_we;
	logic [6:0] buf_addr;
	logic signed [31:0] buf_wdata;
	logic pix_we;
	logic [6:0] pix_addr;
	logic [7:0] pix_byte;

	// both passes index C as [k][inner]
	idct_coef_rom u_rom (
		.idx0_i ({kk, 1'b0, inner}),
		.idx1_i ({kk, 1'b1, inner}),
		.c0_o   (c0),
		.c1_o   (c1)
	);

	assign prod0 = vec[{kk, 1'b0}] * c0; // even k
	assign prod1 = vec[{kk, 1'b1}] * c1; // odd k
	assign sum_nxt = ((kk == 2'd0) ? 32'sd0 : acc) + prod0 + prod1;
	assign t_val = sum_nxt >>> `T_SHIFT;
	assign s_val = sum_nxt >>> `S_SHIFT;

	always_comb begin
		if (s_val < 0) begin
			pix_val = 8'd0;
		end else if (s_val > 255) begin
			pix_val = 8'd255;
		end else begin
			pix_val = s_val[7:0];
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (~Resetn) begin
			state <= S_IDLE;
			pass <= 1'b0;
			outer <= '0;
			inner <= '0;
			kk <= '0;
			ld_cnt <= '0;
			vld <= '0;
			buf_we <= 1'b0;
			pix_we <= 1'b0;
			calc_done_o <= 1'b0;
		end else begin
			buf_we <= 1'b0;
			pix_we <= 1'b0;
			calc_done_o <= 1'b0;
			vld <= {vld[0], 1'b0};
			case (state)
				S_IDLE: if (fetch_done_i) begin
					pass <= 1'b0;
					outer <= '0;
					ld_cnt <= '0;
					state <= S_LOAD;
				end
				S_LOAD: begin
					if (!ld_cnt[3]) begin
						ld_cnt <= ld_cnt + 4'd1;
						vld[0] <= 1'b1;
					end
					if (vld[1] && idx1 == 3'd7) begin
						kk <= '0;
						inner <= '0;
						state <= S_CALC;
					end
				end
				S_CALC: begin
					kk <= kk + 2'd1;
					if (kk == 2'd3) begin
						buf_we <= ~pass;
						pix_we <= pass;
						inner <= inner + 3'd1;
						if (inner == 3'd7) begin
							ld_cnt <= '0;
							outer <= outer + 3'd1;
							if (outer != 3'd7) begin
								state <= S_LOAD;
							end else if (!pass) begin
								pass <= 1'b1;
								state <= S_LOAD;
							end else begin
								calc_done_o <= 1'b1;
								state <= S_IDLE;
							end
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (state == S_LOAD && !ld_cnt[3]) begin
			// S' row at 8i+n, T column at 64+8n+j
			buf_addr <= pass ? {1'b1, ld_cnt[2:0], outer} : {1'b0, outer, ld_cnt[2:0]};
			idx0 <= ld_cnt[2:0];
		end else if (state == S_CALC && kk == 2'd3) begin
			buf_addr <= {1'b1, outer, inner}; // T[i][j]
		end
		idx1 <= idx0;
		if (vld[1]) begin
			vec[idx1] <= buf_q_i;
		end
		if (state == S_CALC) begin
			acc <= sum_nxt;
		end
		buf_wdata <= t_val;
		pix_addr <= {1'b0, inner, outer}; // S[i][j] at 8i+j
		pix_byte <= pix_val;
	end

	assign buf_o = '{addr: buf_addr, wdata: buf_wdata, we: buf_we};
	assign pix_o = '{addr: pix_addr, wdata: {24'd0, pix_byte}, we: pix_we};

endmodule

//--- rtl/idct_pkg.sv
// IDCT shared types
package idct_pkg;

	typedef struct packed {
		logic [7:0] hi; // even column
		logic [7:0] lo;
	} pixel_pair_t;

	// one SRAM word, read as a coefficient or written as a pixel pair
	typedef union packed {
		logic signed [15:0] coef;
		pixel_pair_t pair;
	} sram_word_u;

	typedef struct packed {
		logic [17:0] addr;
		sram_word_u wdata;
		logic we_n;
	} sram_req_t;

	typedef struct packed {
		logic [6:0] addr;
		logic signed [31:0] wdata;
		logic we;
	} dp_port_t;

	typedef logic signed [15:0] coef_t;

endpackage

//--- rtl/idct_top.sv
// IDCT subsystem top
`timescale 1ns/1ps

module idct_top (
	input  logic        Clock,
	input  logic        Resetn,
	input  logic        start_i,
	output logic        done_o,
	output logic [17:0] sram_addr_o,
	output logic [15:0] sram_wdata_o,
	output logic        sram_we_n_o,
	input  logic [15:0] sram_rdata_i
);
	import idct_pkg::*;

	sram_req_t sram_req;
	sram_req_t wb_req;
	dp_port_t fetch_buf;
	dp_port_t mm_buf;
	dp_port_t bb_a;
	dp_port_t mm_pix;
	dp_port_t wb_rd;
	logic signed [31:0] bb_q;
	logic signed [31:0] pix_q;
	logic fetch_busy;
	logic fetch_done;
	logic calc_done;
	logic wb_done;

	// block buffer port A goes to the fetch stage only while it loads
	assign bb_a = fetch_busy ? fetch_buf : mm_buf;

	block_fetch u_fetch (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start_i),
		.wb_done_i    (wb_done),
		.wb_req_i     (wb_req),
		.sram_rdata_i (sram_rdata_i),
		.sram_req_o   (sram_req),
		.buf_o        (fetch_buf),
		.fetch_busy_o (fetch_busy),
		.fetch_done_o (fetch_done),
		.done_o       (done_o)
	);

	idct_matmul u_matmul (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.fetch_done_i (fetch_done),
		.buf_q_i      (bb_q),
		.buf_o        (mm_buf),
		.pix_o        (mm_pix),
		.calc_done_o  (calc_done)
	);

	pixel_writeback u_wb (
		.Clock       (Clock),
		.Resetn      (Resetn),
		.calc_done_i (calc_done),
		.pix_q_i     (pix_q),
		.pix_rd_o    (wb_rd),
		.sram_req_o  (wb_req),
		.wb_done_o   (wb_done)
	);

	// S' at 0..63, T at 64..127; execute stage reads back on port B
	idct_dpram #(.DEPTH(128)) u_blk_buf (
		.Clock (Clock),
		.a_i   (bb_a),
		.b_i   (mm_buf),
		.qa_o  (),
		.qb_o  (bb_q)
	);

	idct_dpram #(.DEPTH(64)) u_pix_buf (
		.Clock (Clock),
		.a_i   (mm_pix),
		.b_i   (wb_rd),
		.qa_o  (),
		.qb_o  (pix_q)
	);

	assign sram_addr_o = sram_req.addr;
	assign sram_wdata_o = sram_req.wdata;
	assign sram_we_n_o = sram_req.we_n;

endmodule

//--- rtl/pixel_writeback.sv
// pixel write-back stage
`timescale 1ns/1ps
`include "idct_defs.svh"

module pixel_writeback (
	input  logic                Clock,
	input  logic                Resetn,
	input  logic                calc_done_i,
	input  logic signed [31:0]  pix_q_i,
	output idct_pkg::dp_port_t  pix_rd_o,
	output idct_pkg::sram_req_t sram_req_o,
	output logic                wb_done_o
);
	import idct_pkg::*;

	localparam logic [17:0] HALF_W = 18'(4 * `IMG_W_BLOCKS);
	localparam logic [7:0] LAST_BCOL = 8'(`IMG_W_BLOCKS - 1);
	localparam logic [7:0] LAST_BROW = 8'(`IMG_H_BLOCKS - 1);

	typedef enum logic {S_IDLE, S_RUN} state_t;

	state_t state;
	logic [7:0] brow;
	logic [7:0] bcol;
	logic [6:0] cnt;
	logic [1:0] vld;
	logic [5:0] rd_addr;
	logic [5:0] idx1;
	logic [17:0] pix_row;
	logic [17:0] pix_col;
	logic [7:0] hi_byte; // held even column
	logic [17:0] wr_addr;
	logic wr_we_n;
	pixel_pair_t wr_pair;

	assign pix_row = 18'({brow, idx1[5:3]});
	assign pix_col = 18'({bcol, idx1[2:1]});

	always_ff @(posedge Clock or negedge Resetn) begin
		if (~Resetn) begin
			state <= S_IDLE;
			brow <= '0;
			bcol <= '0;
			cnt <= '0;
			vld <= '0;
			wr_addr <= `PIX_BASE;
			wr_we_n <= 1'b1;
			wb_done_o <= 1'b0;
		end else begin
			wr_we_n <= 1'b1;
			wb_done_o <= 1'b0;
			vld <= {vld[0], 1'b0};
			case (state)
				S_IDLE: if (calc_done_i) begin
					cnt <= '0;
					state <= S_RUN;
				end
				S_RUN: begin
					if (!cnt[6]) begin
						cnt <= cnt + 7'd1;
						vld[0] <= 1'b1;
					end
					if (vld[1] && idx1[0]) begin
						wr_addr <= `PIX_BASE + pix_row * HALF_W + pix_col;
						wr_we_n <= 1'b0;
					end
					if (vld[1] && idx1 == 6'd63) begin
						wb_done_o <= 1'b1;
						state <= S_IDLE;
						if (bcol == LAST_BCOL) begin
							bcol <= '0;
							brow <= (brow == LAST_BROW) ? 8'd0 : brow + 8'd1;
						end else begin
							bcol <= bcol + 8'd1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (state == S_RUN && !cnt[6]) begin
			rd_addr <= cnt[5:0];
		end
		idx1 <= rd_addr;
		if (vld[1] && !idx1[0]) begin
			hi_byte <= pix_q_i[7:0];
		end
		if (vld[1] && idx1[0]) begin
			wr_pair <= '{hi: hi_byte, lo: pix_q_i[7:0]};
		end
	end

	assign pix_rd_o = '{addr: {1'b0, rd_addr}, wdata: 32'sd0, we: 1'b0};

	always_comb begin
		sram_req_o.addr = wr_addr;
		sram_req_o.wdata.pair = wr_pair;
		sram_req_o.we_n = wr_we_n;
	end

endmodule

//--- test/idct_asserts.sv
// IDCT top-level assertions
`timescale 1ns/1ps
`include "idct_defs.svh"

module idct_asserts (
	input logic        Clock,
	input logic        Resetn,
	input logic        start_i,
	input logic        done_o,
	input logic [17:0] sram_addr_o,
	input logic        sram_we_n_o
);
	logic seen_start; // set by the first start pulse
	int fail_count = 0; // failed assertions so far

	always_ff @(posedge Clock or negedge Resetn) begin
		if (~Resetn) begin
			seen_start <= 1'b0;
		end else if (start_i) begin
			seen_start <= 1'b1;
		end
	end

	done_pulse: assert property (@(posedge Clock) disable iff (!Resetn)
		done_o |=> !done_o)
		else begin
			fail_count++;
			$error("done_o stayed high for more than one cycle");
		end

	// coefficient region is read only
	coef_read_only: assert property (@(posedge Clock) disable iff (!Resetn)
		(sram_addr_o < `PIX_BASE) |-> sram_we_n_o)
		else begin
			fail_count++;
			$error("SRAM write below the pixel region");
		end

	idle_until_start: assert property (@(posedge Clock) disable iff (!Resetn)
		!seen_start |-> sram_we_n_o)
		else begin
			fail_count++;
			$error("SRAM write before the first start_i");
		end

endmodule

bind idct_top idct_asserts u_asserts (
	.Clock       (Clock),
	.Resetn      (Resetn),
	.start_i     (start_i),
	.done_o      (done_o),
	.sram_addr_o (sram_addr_o),
	.sram_we_n_o (sram_we_n_o)
);

//--- test/tb_idct.sv
// IDCT subsystem testbench
`timescale 1ns/1ps
`include "idct_defs.svh"

module tb_idct;
	localparam int COLS = 8 * `IMG_W_BLOCKS;
	localparam int ROWS = 8 * `IMG_H_BLOCKS;
	localparam int NWR = 32 * `IMG_W_BLOCKS * `IMG_H_BLOCKS;
	localparam int TIMEOUT = 50000;

	logic Clock = 1'b0;
	logic Resetn;
	logic start_i;
	logic done_o;
	logic [17:0] sram_addr_o;
	logic [15:0] sram_wdata_o;
	logic sram_we_n_o;
	logic [15:0] sram_rdata_i;

	logic [15:0] sram [0:262143];
	logic [15:0] coef_snap [ROWS*COLS];
	int coef_img [ROWS][COLS];
	int exp_pix [ROWS][COLS];
	int cmat [8][8];
	int unsigned lcg_state = 42;
	int errors = 0;
	int n_pass = 0;
	int n_fail = 0;
	int wr_count = 0;
	int oob_count = 0; // writes outside the pixel region
	bit timed_out = 1'b0;

	idct_top dut (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start_i),
		.done_o       (done_o),
		.sram_addr_o  (sram_addr_o),
		.sram_wdata_o (sram_wdata_o),
		.sram_we_n_o  (sram_we_n_o),
		.sram_rdata_i (sram_rdata_i)
	);

	always #5 Clock = ~Clock;

	// address launched at edge n, data sampled at edge n+2
	always @(posedge Clock) begin
		sram_rdata_i <= sram[sram_addr_o];
		if (sram_we_n_o == 1'b0) begin
			sram[sram_addr_o] <= sram_wdata_o;
			wr_count <= wr_count + 1;
			if (sram_addr_o < `PIX_BASE || sram_addr_o >= `PIX_BASE + NWR) begin
				oob_count <= oob_count + 1;
			end
		end
	end

	function logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function int round_real(input real x);
		return (x < 0.0) ? -$rtoi(0.5 - x) : $rtoi(x + 0.5);
	endfunction

	// row r is spatial, column k the frequency
	function int const_entry(input int r, input int k);
		return (k == 0) ? round_real(4096.0 * $sqrt(1.0 / 8.0)) :
			round_real(2048.0 * $cos((2 * r + 1) * k * 3.14159265358979 / 16.0));
	endfunction

	// mode 0 dc only, 1 random, 2 large dc of both signs
	task automatic fill_image(input int mode);
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				coef_img[r][c] = (mode == 1) ? int'(lcg_next() % 512) - 256 : 0;
			end
		end
		for (int br = 0; br < `IMG_H_BLOCKS; br++) begin
			for (int bc = 0; bc < `IMG_W_BLOCKS; bc++) begin
				case (mode)
					0: coef_img[8*br][8*bc] = int'(lcg_next() % 1024);
					1: coef_img[8*br][8*bc] += 512; // lift the mean
					default: coef_img[8*br][8*bc] = ((br + bc) % 2 == 0) ? 2000 : -2000;
				endcase
			end
		end
	endtask

	task automatic load_image();
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				sram[`COEF_BASE + r * COLS + c] = 16'(coef_img[r][c]);
				coef_snap[r * COLS + c] = 16'(coef_img[r][c]);
			end
		end
	endtask

	task automatic model_image();
		longint acc;
		longint t [8][8];
		longint s;
		for (int br = 0; br < `IMG_H_BLOCKS; br++) begin
			for (int bc = 0; bc < `IMG_W_BLOCKS; bc++) begin
				for (int i = 0; i < 8; i++) begin
					for (int j = 0; j < 8; j++) begin
						acc = 0;
						for (int k = 0; k < 8; k++) begin
							acc += longint'(coef_img[8*br+i][8*bc+k]) * cmat[k][j];
						end
						t[i][j] = acc >>> `T_SHIFT;
					end
				end
				for (int i = 0; i < 8; i++) begin
					for (int j = 0; j < 8; j++) begin
						acc = 0;
						for (int k = 0; k < 8; k++) begin
							acc += cmat[k][i] * t[k][j];
						end
						s = acc >>> `S_SHIFT;
						exp_pix[8*br+i][8*bc+j] = (s < 0) ? 0 : (s > 255) ? 255 : int'(s);
					end
				end
			end
		end
	endtask

	// n_hi counts pixels at 255, n_lo pixels at 0
	task automatic check_image(output int n_hi, output int n_lo);
		logic [17:0] a;
		logic [15:0] w;
		n_hi = 0;
		n_lo = 0;
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c += 2) begin
				a = `PIX_BASE + r * (COLS / 2) + c / 2;
				w = sram[a];
				if (w[15:8] !== 8'(exp_pix[r][c])) begin
					$display("** Error at %0t: sram[%05h].hi expected %02h got %02h",
						$time, a, 8'(exp_pix[r][c]), w[15:8]);
					errors++;
				end
				if (w[7:0] !== 8'(exp_pix[r][c+1])) begin
					$display("** Error at %0t: sram[%05h].lo expected %02h got %02h",
						$time, a, 8'(exp_pix[r][c+1]), w[7:0]);
					errors++;
				end
				n_hi += int'(w[15:8] == 8'd255) + int'(w[7:0] == 8'd255);
				n_lo += int'(w[15:8] == 8'd0) + int'(w[7:0] == 8'd0);
			end
		end
	endtask

	task automatic run_image(output int n_hi, output int n_lo);
		int cycles;
		cycles = 0;
		n_hi = 0;
		n_lo = 0;
		if (!timed_out) begin
			load_image();
			model_image();
			wr_count = 0;
			oob_count = 0;
			@(posedge Clock);
			start_i <= 1'b1;
			@(posedge Clock);
			start_i <= 1'b0;
			@(negedge Clock);
			while (done_o !== 1'b1 && cycles < TIMEOUT) begin
				@(negedge Clock);
				cycles++;
			end
			if (done_o !== 1'b1) begin
				$display("timeout: done_o did not rise within %0d cycles", TIMEOUT);
				timed_out = 1'b1;
				errors++;
			end else begin
				check_image(n_hi, n_lo);
			end
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			n_pass++;
			$display("%s: pass", name);
		end else begin
			n_fail++;
			$display("%s: fail", name);
		end
	endtask

	initial begin
		int e0;
		int n_hi;
		int n_lo;
		Resetn = 1'b0;
		start_i = 1'b0;
		sram_rdata_i = '0;
		for (int a = 0; a < 262144; a++) begin
			sram[a] = 16'(a ^ (a >> 11) ^ 16'h3c5a);
		end
		for (int r = 0; r < 8; r++) begin
			for (int k = 0; k < 8; k++) begin
				cmat[r][k] = const_entry(r, k);
			end
		end
		repeat (5) @(posedge Clock);
		Resetn <= 1'b1;

		e0 = errors;
		@(negedge Clock);
		if (done_o !== 1'b0) begin
			$display("** Error at %0t: done_o expected 0 got %b", $time, done_o);
			errors++;
		end
		if (sram_we_n_o !== 1'b1) begin
			$display("** Error at %0t: sram_we_n_o expected 1 got %b", $time, sram_we_n_o);
			errors++;
		end
		repeat (10) @(negedge Clock);
		if (wr_count != 0) begin
			$display("SRAM was written before start_i");
			errors++;
		end
		report_test("test 1 reset state", e0);

		e0 = errors;
		fill_image(0);
		run_image(n_hi, n_lo);
		report_test("test 2 dc only blocks", e0);

		e0 = errors;
		fill_image(1);
		run_image(n_hi, n_lo);
		report_test("test 3 random coefficients", e0);

		e0 = errors;
		fill_image(2);
		run_image(n_hi, n_lo);
		if (n_hi == 0 || n_lo == 0) begin
			$display("large dc blocks did not clip to both 255 and 0");
			errors++;
		end
		report_test("test 4 saturation", e0);

		// write statistics of the previous run
		e0 = errors;
		if (wr_count != NWR) begin
			$display("** Error at %0t: wr_count expected %0d got %0d", $time, NWR, wr_count);
			errors++;
		end
		if (oob_count != 0) begin
			$display("%0d SRAM writes fell outside the pixel region", oob_count);
			errors++;
		end
		for (int i = 0; i < ROWS * COLS; i++) begin
			if (sram[`COEF_BASE + i] !== coef_snap[i]) begin
				$display("** Error at %0t: sram[%05h] expected %04h got %04h",
					$time, `COEF_BASE + i, coef_snap[i], sram[`COEF_BASE + i]);
				errors++;
			end
		end
		report_test("test 5 write count and region", e0);

		e0 = errors;
		fill_image(1);
		run_image(n_hi, n_lo);
		report_test("test 6 second start", e0);

		if (dut.u_asserts.fail_count != 0) begin
			$display("%0d bound assertion checks failed", dut.u_asserts.fail_count);
			errors += dut.u_asserts.fail_count;
		end

		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+rtl
rtl/idct_pkg.sv
rtl/idct_dpram.sv
rtl/block_fetch.sv
rtl/idct_coef_rom.sv
rtl/idct_matmul.sv
rtl/pixel_writeback.sv
rtl/idct_top.sv
test/idct_asserts.sv
test/tb_idct.sv
